// File: design/common_pkg.sv
// Shared memory subsystem definitions
package common_pkg;

    // Bus and memory sizes
    localparam int DATA_WIDTH     = 8;
    localparam int RAM_ADDR_WIDTH = 17;
    localparam int WB_ADDR_WIDTH  = RAM_ADDR_WIDTH;

    // System clock period in ns (25 MHz)
    localparam int WB_CLOCK_NS = 40;

    // Round a delay in ns up to whole clock cycles
    function automatic int ns_to_cycles(input int ns);
        return (ns + WB_CLOCK_NS - 1) / WB_CLOCK_NS;
    endfunction

    // Cycles OE is held before read data is sampled (tAA = 55 ns)
    localparam int READ_HOLD_COUNT  = ns_to_cycles(55);
    // Cycles the WE pulse is extended (tWP = 45 ns)
    localparam int WRITE_HOLD_COUNT = ns_to_cycles(45);
    // Width of the SRAM controller's cycle counter
    localparam int RAM_COUNT_WIDTH  = 3;

    // SRAM controller states, one-hot
    localparam logic [3:0] RAM_READY   = 4'b0001;
    localparam logic [3:0] RAM_READING = 4'b0010;
    localparam logic [3:0] RAM_HIGHZ   = 4'b0100;
    localparam logic [3:0] RAM_WRITING = 4'b1000;

    // Arbiter slot states
    localparam logic [1:0] ARB_VIDEO = 2'd0;
    localparam logic [1:0] ARB_MCU   = 2'd1;
    localparam logic [1:0] ARB_BUS   = 2'd2;

    // Reserved bits between opcode and address in the command word
    localparam int CMD_RSVD_WIDTH = 32 - 2 - RAM_ADDR_WIDTH - DATA_WIDTH;

    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } cmd_op_e;

    // Write view carries the data byte in the low field
    typedef struct packed {
        cmd_op_e                   op;
        logic [CMD_RSVD_WIDTH-1:0] rsvd;
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     data;
    } cmd_wr_t;

    // Read view leaves the low byte unused
    typedef struct packed {
        cmd_op_e                   op;
        logic [CMD_RSVD_WIDTH-1:0] rsvd;
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     rsvd_lo;
    } cmd_rd_t;

    typedef union packed {
        cmd_wr_t wr;
        cmd_rd_t rd;
    } mcu_cmd_u;

    // Decoder to arbiter request
    typedef struct packed {
        logic                      we;
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     wdata;
    } mem_req_t;

    // Arbiter to decoder read response
    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: design/mcu_cmd_decoder.sv
// MCU command decoder
`timescale 1ns/1ps

module mcu_cmd_decoder (
    input  logic                              wb_clock_i,
    input  logic                              rst_i,
    // Command port from the serial bridge
    input  common_pkg::mcu_cmd_u              mcu_cmd_i,
    input  logic                              mcu_valid_i,
    output logic                              mcu_ready_o,
    output logic [common_pkg::DATA_WIDTH-1:0] mcu_rdata_o,
    output logic                              mcu_rdata_valid_o,
    // Request toward the arbiter
    output common_pkg::mem_req_t              req_o,
    output logic                              req_valid_o,
    input  logic                              req_ready_i,
    // Read response from the arbiter
    input  common_pkg::mem_rsp_t              rsp_i,
    input  logic                              rsp_valid_i
);
    import common_pkg::*;

    mcu_cmd_u cmd_q;
    cmd_op_e  new_op;
    logic     busy;
    logic     take_cmd;

    // Opcode of the incoming word, read through the read view
    assign new_op      = mcu_cmd_i.rd.op;
    assign mcu_ready_o = !busy;

    // NOPs and unknown opcodes are accepted but never issued
    assign take_cmd = mcu_valid_i && mcu_ready_o &&
                      (new_op == CMD_READ || new_op == CMD_WRITE);

    // Request fields come from the held command word
    assign req_o.we    = (cmd_q.wr.op == CMD_WRITE);
    assign req_o.addr  = cmd_q.rd.addr;
    assign req_o.wdata = cmd_q.wr.data;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            busy              <= 1'b0;
            req_valid_o       <= 1'b0;
            mcu_rdata_valid_o <= 1'b0;
        end else begin
            mcu_rdata_valid_o <= 1'b0;
            if (take_cmd) begin
                busy        <= 1'b1;
                req_valid_o <= 1'b1;
            end
            // Handoff to the arbiter
            if (req_valid_o && req_ready_i) begin
                req_valid_o <= 1'b0;
                // A write is finished once the arbiter owns it
                if (req_o.we) begin
                    busy <= 1'b0;
                end
            end
            // Read data back, command complete
            if (rsp_valid_i && busy) begin
                mcu_rdata_valid_o <= 1'b1;
                busy              <= 1'b0;
            end
        end
    end

    // Command word and read data
    always_ff @(posedge wb_clock_i) begin
        if (take_cmd) begin
            cmd_q <= mcu_cmd_i;
        end
        if (rsp_valid_i && busy) begin
            mcu_rdata_o <= rsp_i.rdata;
        end
    end

endmodule

// File: design/bus_arbiter.sv
// Video and MCU bus arbiter
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                                 wb_clock_i,
    input  logic                                 rst_i,
    // MCU request and response
    input  common_pkg::mem_req_t                 req_i,
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    output common_pkg::mem_rsp_t                 rsp_o,
    output logic                                 rsp_valid_o,
    // Video fetch port
    input  logic [common_pkg::RAM_ADDR_WIDTH-1:0] video_addr_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     video_data_o,
    output logic                                 video_valid_o,
    // Wishbone B4 pipelined master
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_data_o,
    output logic                                 wb_we_o,
    output logic                                 wb_cycle_o,
    output logic                                 wb_strobe_o,
    output logic                                 wb_sel_o,
    input  logic [common_pkg::DATA_WIDTH-1:0]    wb_data_i,
    input  logic                                 wb_stall_i,
    input  logic                                 wb_ack_i
);
    import common_pkg::*;

    logic [1:0] state;
    // Owner of the transfer in flight
    logic       owner_video;

    // MCU requests are taken only at the start of an MCU slot
    assign req_ready_o = (state == ARB_MCU);
    // Single peripheral, selected for the whole cycle
    assign wb_sel_o    = wb_cycle_o;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            state         <= ARB_VIDEO;
            owner_video   <= 1'b0;
            wb_cycle_o    <= 1'b0;
            wb_strobe_o   <= 1'b0;
            rsp_valid_o   <= 1'b0;
            video_valid_o <= 1'b0;
        end else begin
            rsp_valid_o   <= 1'b0;
            video_valid_o <= 1'b0;
            case (state)
                ARB_VIDEO: begin
                    // Video slot always issues a read
                    wb_cycle_o  <= 1'b1;
                    wb_strobe_o <= 1'b1;
                    owner_video <= 1'b1;
                    state       <= ARB_BUS;
                end
                ARB_MCU: begin
                    if (req_valid_i) begin
                        wb_cycle_o  <= 1'b1;
                        wb_strobe_o <= 1'b1;
                        owner_video <= 1'b0;
                        state       <= ARB_BUS;
                    end else begin
                        // Empty MCU slot, go straight to video
                        state <= ARB_VIDEO;
                    end
                end
                ARB_BUS: begin
                    // Strobe drops once the peripheral takes it
                    if (wb_strobe_o && !wb_stall_i) begin
                        wb_strobe_o <= 1'b0;
                    end
                    if (wb_ack_i) begin
                        wb_cycle_o  <= 1'b0;
                        wb_strobe_o <= 1'b0;
                        if (owner_video) begin
                            video_valid_o <= 1'b1;
                            state         <= ARB_MCU;
                        end else begin
                            // Writes complete without a response
                            rsp_valid_o <= !wb_we_o;
                            state       <= ARB_VIDEO;
                        end
                    end
                end
                default: begin
                    wb_cycle_o  <= 1'b0;
                    wb_strobe_o <= 1'b0;
                    state       <= ARB_VIDEO;
                end
            endcase
        end
    end

    // Bus payload and returned bytes
    always_ff @(posedge wb_clock_i) begin
        if (state == ARB_VIDEO) begin
            wb_addr_o <= video_addr_i;
            wb_we_o   <= 1'b0;
        end
        if (state == ARB_MCU && req_valid_i) begin
            wb_addr_o <= req_i.addr;
            wb_data_o <= req_i.wdata;
            wb_we_o   <= req_i.we;
        end
        if (state == ARB_BUS && wb_ack_i) begin
            if (owner_video) begin
                video_data_o <= wb_data_i;
            end else begin
                rsp_o.rdata <= wb_data_i;
            end
        end
    end

endmodule

// File: design/ram.sv
// Asynchronous SRAM controller
`timescale 1ns/1ps

module ram (
    input  logic                                  wb_clock_i,
    input  logic                                  rst_i,
    // Wishbone B4 pipelined peripheral
    input  logic [common_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    // Byte to write
    input  logic [common_pkg::DATA_WIDTH-1:0]     wb_data_i,
    // Byte read back, valid with ack
    output logic [common_pkg::DATA_WIDTH-1:0]     wb_data_o,
    // High for write, low for read
    input  logic                                  wb_we_i,
    input  logic                                  wb_cycle_i,
    input  logic                                  wb_strobe_i,
    output logic                                  wb_stall_o,
    output logic                                  wb_ack_o,
    input  logic                                  wb_sel_i,
    // SRAM pins
    output logic [common_pkg::RAM_ADDR_WIDTH-1:0] sram_addr_o,
    output logic                                  sram_oe_o,
    output logic                                  sram_we_o,
    input  logic [common_pkg::DATA_WIDTH-1:0]     sram_data_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     sram_data_o,
    output logic                                  sram_data_oe_o
);
    import common_pkg::*;

    // Part timing, 55 ns device
    //   Read: address and OE rise together, data valid 55 ns later
    //   Data floats up to 20 ns after OE falls, hence the HIGHZ cycle
    //   Write: address, WE and data rise together, WE pulse at least 45 ns
    //   Address setup and data hold are zero, so WE may fall with ack

    logic [3:0]                 state;
    logic [RAM_COUNT_WIDTH-1:0] cycle_count;
    logic                       accept;
    logic                       read_done;
    logic                       write_done;

    // New transfer offered while idle
    assign accept     = wb_sel_i && wb_cycle_i && wb_strobe_i;
    // Sample point, READ_HOLD_COUNT+2 edges after acceptance
    assign read_done  = (cycle_count == RAM_COUNT_WIDTH'(READ_HOLD_COUNT + 1));
    // WE has then been high for WRITE_HOLD_COUNT+1 cycles
    assign write_done = (cycle_count == RAM_COUNT_WIDTH'(WRITE_HOLD_COUNT));

    // Drive the data pins only while writing
    assign sram_data_oe_o = sram_we_o;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            state       <= RAM_READY;
            cycle_count <= '0;
            wb_ack_o    <= 1'b0;
            wb_stall_o  <= 1'b0;
            sram_oe_o   <= 1'b0;
            sram_we_o   <= 1'b0;
        end else begin
            case (state)
                RAM_READY: begin
                    wb_ack_o   <= 1'b0;
                    wb_stall_o <= 1'b0;
                    sram_oe_o  <= 1'b0;
                    sram_we_o  <= 1'b0;
                    if (accept) begin
                        cycle_count <= '0;
                        // Busy until the transfer is done
                        wb_stall_o  <= 1'b1;
                        sram_oe_o   <= !wb_we_i;
                        sram_we_o   <= wb_we_i;
                        state       <= wb_we_i ? RAM_WRITING : RAM_READING;
                    end
                end
                RAM_READING: begin
                    if (read_done) begin
                        cycle_count <= '0;
                        wb_ack_o    <= 1'b1;
                        sram_oe_o   <= 1'b0;
                        state       <= RAM_HIGHZ;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                RAM_HIGHZ: begin
                    // Turnaround while the SRAM releases the bus
                    wb_ack_o   <= 1'b0;
                    wb_stall_o <= 1'b0;
                    state      <= RAM_READY;
                end
                RAM_WRITING: begin
                    if (write_done) begin
                        cycle_count <= '0;
                        wb_ack_o    <= 1'b1;
                        wb_stall_o  <= 1'b0;
                        sram_we_o   <= 1'b0;
                        state       <= RAM_READY;
                    end else begin
                        cycle_count <= cycle_count + 1'b1;
                    end
                end
                default: begin
                    wb_ack_o   <= 1'b0;
                    wb_stall_o <= 1'b0;
                    sram_oe_o  <= 1'b0;
                    sram_we_o  <= 1'b0;
                    state      <= RAM_READY;
                end
            endcase
        end
    end

    // Address, write data and read capture
    always_ff @(posedge wb_clock_i) begin
        if (state == RAM_READY && accept) begin
            sram_addr_o <= wb_addr_i[RAM_ADDR_WIDTH-1:0];
            sram_data_o <= wb_data_i;
        end
        // Sampled while OE is still high
        if (state == RAM_READING && read_done) begin
            wb_data_o <= sram_data_i;
        end
    end

endmodule

// File: design/pet_mem_top.sv
// Shared SRAM access top level
`timescale 1ns/1ps

module pet_mem_top (
    input  logic                                  wb_clock_i,
    input  logic                                  rst_i,
    // MCU command port
    input  common_pkg::mcu_cmd_u                  mcu_cmd_i,
    input  logic                                  mcu_valid_i,
    output logic                                  mcu_ready_o,
    output logic [common_pkg::DATA_WIDTH-1:0]     mcu_rdata_o,
    output logic                                  mcu_rdata_valid_o,
    // Video fetch port
    input  logic [common_pkg::RAM_ADDR_WIDTH-1:0] video_addr_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     video_data_o,
    output logic                                  video_valid_o,
    // SRAM pins
    output logic [common_pkg::RAM_ADDR_WIDTH-1:0] sram_addr_o,
    output logic                                  sram_oe_o,
    output logic                                  sram_we_o,
    input  logic [common_pkg::DATA_WIDTH-1:0]     sram_data_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     sram_data_o,
    output logic                                  sram_data_oe_o
);
    import common_pkg::*;

    // Decoder to arbiter
    mem_req_t req;
    logic     req_valid;
    logic     req_ready;
    mem_rsp_t rsp;
    logic     rsp_valid;

    // Arbiter to SRAM controller
    logic [WB_ADDR_WIDTH-1:0] wb_addr;
    logic [DATA_WIDTH-1:0]    wb_wdata;
    logic [DATA_WIDTH-1:0]    wb_rdata;
    logic                     wb_we;
    logic                     wb_cycle;
    logic                     wb_strobe;
    logic                     wb_sel;
    logic                     wb_stall;
    logic                     wb_ack;

    mcu_cmd_decoder i_decoder (
        .wb_clock_i        (wb_clock_i),
        .rst_i             (rst_i),
        .mcu_cmd_i         (mcu_cmd_i),
        .mcu_valid_i       (mcu_valid_i),
        .mcu_ready_o       (mcu_ready_o),
        .mcu_rdata_o       (mcu_rdata_o),
        .mcu_rdata_valid_o (mcu_rdata_valid_o),
        .req_o             (req),
        .req_valid_o       (req_valid),
        .req_ready_i       (req_ready),
        .rsp_i             (rsp),
        .rsp_valid_i       (rsp_valid)
    );

    bus_arbiter i_arbiter (
        .wb_clock_i    (wb_clock_i),
        .rst_i         (rst_i),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .rsp_o         (rsp),
        .rsp_valid_o   (rsp_valid),
        .video_addr_i  (video_addr_i),
        .video_data_o  (video_data_o),
        .video_valid_o (video_valid_o),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_wdata),
        .wb_we_o       (wb_we),
        .wb_cycle_o    (wb_cycle),
        .wb_strobe_o   (wb_strobe),
        .wb_sel_o      (wb_sel),
        .wb_data_i     (wb_rdata),
        .wb_stall_i    (wb_stall),
        .wb_ack_i      (wb_ack)
    );

    ram i_ram (
        .wb_clock_i     (wb_clock_i),
        .rst_i          (rst_i),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_wdata),
        .wb_data_o      (wb_rdata),
        .wb_we_i        (wb_we),
        .wb_cycle_i     (wb_cycle),
        .wb_strobe_i    (wb_strobe),
        .wb_stall_o     (wb_stall),
        .wb_ack_o       (wb_ack),
        .wb_sel_i       (wb_sel),
        .sram_addr_o    (sram_addr_o),
        .sram_oe_o      (sram_oe_o),
        .sram_we_o      (sram_we_o),
        .sram_data_i    (sram_data_i),
        .sram_data_o    (sram_data_o),
        .sram_data_oe_o (sram_data_oe_o)
    );

endmodule

// File: verification/sram_model.sv
// Behavioral asynchronous SRAM
`timescale 1ns/1ps

module sram_model (
    input  logic [common_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic                                  oe_i,
    input  logic                                  we_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]     data_i,
    input  logic                                  data_oe_i,
    output logic [common_pkg::DATA_WIDTH-1:0]     data_o
);
    import common_pkg::*;

    // Part limits in ns, 55 ns device
    localparam realtime T_AA = 55.0;
    localparam realtime T_WP = 45.0;
    localparam int      DEPTH = 1 << RAM_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];
    realtime               oe_rise;
    realtime               we_rise;
    logic                  oe_high;
    logic                  we_high;
    int                    violation_count;

    // Preload, address folded to a byte then XOR 0x5A
    function automatic logic [DATA_WIDTH-1:0] fill_byte(input int addr);
        logic [RAM_ADDR_WIDTH-1:0] a;
        a = RAM_ADDR_WIDTH'(addr);
        return a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h5A;
    endfunction

    initial begin
        violation_count = 0;
        oe_high         = 1'b0;
        we_high         = 1'b0;
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = fill_byte(a);
        end
    end

    // Read data only while OE is asserted
    assign data_o = oe_i ? mem[addr_i] : 8'hzz;

    // OE falls on the edge where the controller samples the data
    always @(oe_i) begin
        if (oe_i === 1'b1) begin
            oe_rise = $realtime;
            oe_high = 1'b1;
            if (data_oe_i === 1'b1) begin
                violation_count++;
                $display("ERROR: SRAM read started while the controller drives the data pins");
            end
        end else if (oe_high) begin
            oe_high = 1'b0;
            if ($realtime - oe_rise < T_AA) begin
                violation_count++;
                $display("ERROR: SRAM data sampled only %0.1f ns after OE",
                         $realtime - oe_rise);
            end
        end
    end

    // Write lands on the falling edge of WE
    always @(we_i) begin
        if (we_i === 1'b1) begin
            we_rise = $realtime;
            we_high = 1'b1;
        end else if (we_high) begin
            we_high = 1'b0;
            if ($realtime - we_rise < T_WP) begin
                violation_count++;
                $display("ERROR: SRAM WE pulse only %0.1f ns wide", $realtime - we_rise);
            end
            mem[addr_i] = data_i;
        end
    end

endmodule

// File: verification/tb_pet_mem.sv
// Shared SRAM subsystem testbench
`timescale 1ns/1ps

module tb_pet_mem;
    import common_pkg::*;

    // One MCU command and the byte a read should return
    typedef struct packed {
        cmd_op_e                   op;
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     data;
        logic [DATA_WIDTH-1:0]     exp_data;
    } stim_entry_t;

    localparam int NUM_STIM        = 16;
    localparam int WATCHDOG_CYCLES = NUM_STIM * 40 + 200;
    // Video fetches stay in a window the MCU also writes
    localparam logic [RAM_ADDR_WIDTH-1:0] VIDEO_BASE = 17'h00020;

    stim_entry_t stim_table [NUM_STIM] = '{
        '{CMD_READ,  17'h00025, 8'h00, 8'h7F},
        '{CMD_READ,  17'h1FF3C, 8'h00, 8'h98},
        '{CMD_WRITE, 17'h00023, 8'hA5, 8'h00},
        '{CMD_WRITE, 17'h00024, 8'h3C, 8'h00},
        '{CMD_READ,  17'h00023, 8'h00, 8'hA5},
        '{CMD_READ,  17'h00024, 8'h00, 8'h3C},
        '{CMD_READ,  17'h00022, 8'h00, 8'h78},
        // NOP with data, must not reach memory
        '{CMD_NOP,   17'h00021, 8'h11, 8'h00},
        '{CMD_WRITE, 17'h00022, 8'h00, 8'h00},
        '{CMD_READ,  17'h00023, 8'h00, 8'hA5},
        '{CMD_READ,  17'h00022, 8'h00, 8'h00},
        '{CMD_READ,  17'h00021, 8'h00, 8'h7B},
        '{CMD_WRITE, 17'h0002F, 8'hFF, 8'h00},
        '{CMD_NOP,   17'h00000, 8'h00, 8'h00},
        '{CMD_READ,  17'h0002F, 8'h00, 8'hFF},
        '{CMD_READ,  17'h0A120, 8'h00, 8'hDB}
    };

    logic                      wb_clock_i;
    logic                      rst_i;
    mcu_cmd_u                  mcu_cmd_i;
    logic                      mcu_valid_i;
    logic                      mcu_ready_o;
    logic [DATA_WIDTH-1:0]     mcu_rdata_o;
    logic                      mcu_rdata_valid_o;
    logic [RAM_ADDR_WIDTH-1:0] video_addr_i;
    logic [DATA_WIDTH-1:0]     video_data_o;
    logic                      video_valid_o;
    logic [RAM_ADDR_WIDTH-1:0] sram_addr_o;
    logic                      sram_oe_o;
    logic                      sram_we_o;
    logic [DATA_WIDTH-1:0]     sram_data_i;
    logic [DATA_WIDTH-1:0]     sram_data_o;
    logic                      sram_data_oe_o;

    // Reference copy, bytes the MCU has written
    logic [DATA_WIDTH-1:0] ref_mem [int];
    // Reads in flight, oldest first
    logic [DATA_WIDTH-1:0] read_exp_q [$];
    string                 read_name_q [$];
    int errors       = 0;
    int checks       = 0;
    int reads_issued = 0;
    int reads_done   = 0;
    int video_count  = 0;

    pet_mem_top i_dut (
        .wb_clock_i        (wb_clock_i),
        .rst_i             (rst_i),
        .mcu_cmd_i         (mcu_cmd_i),
        .mcu_valid_i       (mcu_valid_i),
        .mcu_ready_o       (mcu_ready_o),
        .mcu_rdata_o       (mcu_rdata_o),
        .mcu_rdata_valid_o (mcu_rdata_valid_o),
        .video_addr_i      (video_addr_i),
        .video_data_o      (video_data_o),
        .video_valid_o     (video_valid_o),
        .sram_addr_o       (sram_addr_o),
        .sram_oe_o         (sram_oe_o),
        .sram_we_o         (sram_we_o),
        .sram_data_i       (sram_data_i),
        .sram_data_o       (sram_data_o),
        .sram_data_oe_o    (sram_data_oe_o)
    );

    sram_model i_sram (
        .addr_i    (sram_addr_o),
        .oe_i      (sram_oe_o),
        .we_i      (sram_we_o),
        .data_i    (sram_data_o),
        .data_oe_i (sram_data_oe_o),
        .data_o    (sram_data_i)
    );

    // Power-up contents, address folded to a byte then XOR 0x5A
    function automatic logic [DATA_WIDTH-1:0] pattern_byte(input logic [16:0] addr);
        return addr[7:0] ^ addr[15:8] ^ {7'b0, addr[16]} ^ 8'h5A;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_byte(input logic [16:0] addr);
        if (ref_mem.exists(int'(addr))) begin
            return ref_mem[int'(addr)];
        end
        return pattern_byte(addr);
    endfunction

    function automatic mcu_cmd_u build_cmd(input stim_entry_t entry);
        mcu_cmd_u cmd;
        cmd         = '0;
        cmd.wr.op   = entry.op;
        cmd.wr.addr = entry.addr;
        cmd.wr.data = entry.data;
        return cmd;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
        end
    endtask

    initial begin
        wb_clock_i = 1'b0;
        forever #20 wb_clock_i = ~wb_clock_i;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge wb_clock_i);
        $display("ERROR: watchdog expired after %0d cycles, DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // Read completions, must match the issue order
    initial begin
        forever begin
            @(posedge wb_clock_i);
            if (!rst_i && mcu_rdata_valid_o) begin
                if (read_exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR: MCU read data returned with no read outstanding");
                end else begin
                    check_value(read_name_q.pop_front(), read_exp_q.pop_front(), mcu_rdata_o);
                    reads_done++;
                end
            end
        end
    end

    // Video port, new random address after each fetch
    initial begin
        void'($urandom(92810));
        video_addr_i = VIDEO_BASE + 17'd5;
        forever begin
            @(posedge wb_clock_i);
            if (!rst_i && video_valid_o) begin
                check_value($sformatf("video read 0x%05h", video_addr_i),
                            expected_byte(video_addr_i), video_data_o);
                video_count++;
                video_addr_i <= VIDEO_BASE + RAM_ADDR_WIDTH'($urandom % 16);
            end
        end
    end

    initial begin
        stim_entry_t pend;
        logic        pending_write;
        int          violations;
        pending_write = 1'b0;
        rst_i         = 1'b1;
        mcu_valid_i   = 1'b0;
        mcu_cmd_i     = '0;
        repeat (2) @(posedge wb_clock_i);
        rst_i <= 1'b0;
        @(posedge wb_clock_i);

        // Idle state straight out of reset
        check_value("reset sram_oe_o", 8'h00, sram_oe_o);
        check_value("reset sram_we_o", 8'h00, sram_we_o);
        check_value("reset sram_data_oe_o", 8'h00, sram_data_oe_o);
        check_value("reset mcu_rdata_valid_o", 8'h00, mcu_rdata_valid_o);
        check_value("reset video_valid_o", 8'h00, video_valid_o);
        check_value("reset mcu_ready_o", 8'h01, mcu_ready_o);

        // Valid stays high, so each command waits on ready
        for (int i = 0; i < NUM_STIM; i++) begin
            mcu_cmd_i   <= build_cmd(stim_table[i]);
            mcu_valid_i <= 1'b1;
            do begin
                @(posedge wb_clock_i);
            end while (!mcu_ready_o);
            // Ready again, so the previous write is already with the arbiter
            if (pending_write) begin
                ref_mem[int'(pend.addr)] = pend.data;
                pending_write            = 1'b0;
            end
            if (stim_table[i].op == CMD_READ) begin
                read_exp_q.push_back(stim_table[i].exp_data);
                read_name_q.push_back($sformatf("entry %0d read 0x%05h", i,
                                                stim_table[i].addr));
                reads_issued++;
            end
            if (stim_table[i].op == CMD_WRITE) begin
                pend          = stim_table[i];
                pending_write = 1'b1;
            end
            // Old command still offered, must be refused
            if (stim_table[i].op != CMD_NOP) begin
                @(posedge wb_clock_i);
                check_value($sformatf("entry %0d ready after accept", i), 8'h00, mcu_ready_o);
            end
        end
        mcu_valid_i <= 1'b0;
        do begin
            @(posedge wb_clock_i);
        end while (!mcu_ready_o);
        if (pending_write) begin
            ref_mem[int'(pend.addr)] = pend.data;
        end
        while (read_exp_q.size() != 0) begin
            @(posedge wb_clock_i);
        end
        // More video fetches over the freshly written bytes
        repeat (60) @(posedge wb_clock_i);

        check_value("read completions", 8'(reads_issued), 8'(reads_done));
        if (video_count == 0) begin
            errors++;
            $display("ERROR: the video port never returned a byte");
        end
        violations = i_sram.violation_count;
        $display("Checks: %0d, video reads: %0d, errors: %0d, SRAM timing violations: %0d",
                 checks, video_count, errors, violations);
        if (errors == 0 && violations == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/common_pkg.sv
design/mcu_cmd_decoder.sv
design/bus_arbiter.sv
design/ram.sv
design/pet_mem_top.sv
verification/sram_model.sv
verification/tb_pet_mem.sv

// File: Bender.yml
package:
  name: pet_mem

sources:
  # Shared SRAM subsystem RTL
  - files:
      - design/common_pkg.sv
      - design/mcu_cmd_decoder.sv
      - design/bus_arbiter.sv
      - design/ram.sv
      - design/pet_mem_top.sv
  # SRAM model and testbench
  - target: simulation
    files:
      - verification/sram_model.sv
      - verification/tb_pet_mem.sv
